// File: src/stream_arb_pkg.sv
// shared sizes, arbitration mode codes and register map for the stream merger RTL and testbench
package stream_arb_pkg;

    // stream sizes
    localparam int NUM_INPUTS = 4;
    localparam int DATA_W     = 32;
    localparam int SEL_W      = $clog2(NUM_INPUTS);

    // register port sizes
    localparam int AXI_ADDR_W = 8;
    localparam int AXI_DATA_W = 32;
    localparam int AXI_STRB_W = AXI_DATA_W / 8;

    // accepted beats per input
    localparam int CNT_W = 32;

    // arbitration policy, held in bit 0 of the control register
    localparam logic ARB_MODE_RR   = 1'b0;
    localparam logic ARB_MODE_PRIO = 1'b1;

    // register map
    localparam logic [AXI_ADDR_W-1:0] REG_CTRL     = 8'h00;
    // counter i lives at REG_CNT_BASE + 4*i
    localparam logic [AXI_ADDR_W-1:0] REG_CNT_BASE = 8'h10;

    // control register fields
    localparam int CTRL_MODE_BIT = 0;
    localparam int CTRL_MASK_LSB = 4;

    // AXI response codes
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

// File: src/stream_arbiter.sv
// grant logic for the merger, round-robin or fixed priority over the masked request vector
`timescale 1ns/10ps

module stream_arbiter (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [stream_arb_pkg::NUM_INPUTS-1:0] requests,
    input  logic                                  mode,
    output logic                                  grant_valid,
    output logic [stream_arb_pkg::SEL_W-1:0]      grant_index,
    output logic [stream_arb_pkg::NUM_INPUTS-1:0] grant_onehot,
    input  logic                                  grant_ready
);
    import stream_arb_pkg::*;

    // round-robin search starts just after the last taken grant
    logic [SEL_W-1:0] last_index;
    logic [SEL_W-1:0] prio_index;
    logic [SEL_W-1:0] rr_index;

    // lowest requesting index wins
    always_comb begin
        prio_index = '0;
        for (int i = NUM_INPUTS - 1; i >= 0; i--) begin
            if (requests[i]) begin
                prio_index = SEL_W'(i);
            end
        end
    end

    // walk down so the nearest requester after last_index is the one left standing
    always_comb begin
        rr_index = '0;
        for (int k = NUM_INPUTS; k >= 1; k--) begin
            if (requests[(int'(last_index) + k) % NUM_INPUTS]) begin
                rr_index = SEL_W'((int'(last_index) + k) % NUM_INPUTS);
            end
        end
    end

    assign grant_valid = |requests;
    assign grant_index = (mode == ARB_MODE_PRIO) ? prio_index : rr_index;

    always_comb begin
        grant_onehot = '0;
        if (grant_valid) begin
            grant_onehot[grant_index] = 1'b1;
        end
    end

    // starts at the top input so the first round-robin grant goes to input 0
    always_ff @(posedge clk) begin
        if (rst) begin
            last_index <= SEL_W'(NUM_INPUTS - 1);
        end else if (grant_valid && grant_ready) begin
            last_index <= grant_index;
        end
    end

    // a grant only ever points at a live request
    a_grant_legal: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(grant_onehot) && ((grant_onehot & ~requests) == '0)
    );

endmodule

// File: src/elastic_buffer.sv
// two-entry skid buffer with registered output and registered ready, one beat per cycle
`timescale 1ns/10ps

module elastic_buffer #(
    parameter int DATAW = 1
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             valid_in,
    input  logic [DATAW-1:0] data_in,
    output logic             ready_in,
    output logic             valid_out,
    output logic [DATAW-1:0] data_out,
    input  logic             ready_out
);

    logic             main_valid;
    logic [DATAW-1:0] main_data;
    logic             skid_valid;
    logic [DATAW-1:0] skid_data;
    logic             skid_valid_n;
    logic             ready_r;
    logic             push;
    logic             pop;

    // ready_r is only ever high while the skid slot is empty
    assign push = valid_in && ready_r;
    // output register free to take a new beat
    assign pop  = !main_valid || ready_out;

    always_comb begin
        skid_valid_n = skid_valid;
        if (pop) begin
            skid_valid_n = 1'b0;
        end else if (push) begin
            skid_valid_n = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
            ready_r    <= 1'b0;
        end else begin
            skid_valid <= skid_valid_n;
            ready_r    <= !skid_valid_n;
            if (pop) begin
                main_valid <= skid_valid || push;
            end
        end
    end

    // payload path, the skid slot tracks the input until it is occupied
    always_ff @(posedge clk) begin
        if (pop) begin
            main_data <= skid_valid ? skid_data : data_in;
        end
        if (!skid_valid) begin
            skid_data <= data_in;
        end
    end

    assign ready_in  = ready_r;
    assign valid_out = main_valid;
    assign data_out  = main_data;

    a_out_stable: assert property (
        @(posedge clk) disable iff (rst)
        (valid_out && !ready_out) |=> (valid_out && $stable(data_out))
    );

endmodule

// File: src/stream_arb.sv
// many-to-one stream merger, arbitrates the inputs into one buffered output tagged with its source
`timescale 1ns/10ps

module stream_arb (
    input  logic                                                         clk,
    input  logic                                                         rst,
    input  logic [stream_arb_pkg::NUM_INPUTS-1:0]                        valid_in,
    input  logic [stream_arb_pkg::NUM_INPUTS-1:0][stream_arb_pkg::DATA_W-1:0] data_in,
    output logic [stream_arb_pkg::NUM_INPUTS-1:0]                        ready_in,
    output logic                                                         valid_out,
    output logic [stream_arb_pkg::DATA_W-1:0]                            data_out,
    output logic [stream_arb_pkg::SEL_W-1:0]                             sel_out,
    input  logic                                                         ready_out,
    input  logic                                                         mode,
    input  logic [stream_arb_pkg::NUM_INPUTS-1:0]                        enable_mask,
    output logic                                                         accept_valid,
    output logic [stream_arb_pkg::SEL_W-1:0]                             accept_index
);
    import stream_arb_pkg::*;

    logic [NUM_INPUTS-1:0] requests;
    logic                  arb_valid;
    logic [SEL_W-1:0]      arb_index;
    logic [NUM_INPUTS-1:0] arb_onehot;
    logic [DATA_W-1:0]     sel_data;
    logic                  buf_ready;

    // disabled inputs are never offered to the arbiter
    assign requests = valid_in & enable_mask;

    stream_arbiter u_arbiter (
        .clk          (clk),
        .rst          (rst),
        .requests     (requests),
        .mode         (mode),
        .grant_valid  (arb_valid),
        .grant_index  (arb_index),
        .grant_onehot (arb_onehot),
        .grant_ready  (buf_ready)
    );

    // and-or select on the one-hot grant
    always_comb begin
        sel_data = '0;
        for (int i = 0; i < NUM_INPUTS; i++) begin
            sel_data = sel_data | (data_in[i] & {DATA_W{arb_onehot[i]}});
        end
    end

    assign ready_in = {NUM_INPUTS{buf_ready}} & arb_onehot;

    elastic_buffer #(
        .DATAW (SEL_W + DATA_W)
    ) u_out_buf (
        .clk       (clk),
        .rst       (rst),
        .valid_in  (arb_valid),
        .data_in   ({arb_index, sel_data}),
        .ready_in  (buf_ready),
        .valid_out (valid_out),
        .data_out  ({sel_out, data_out}),
        .ready_out (ready_out)
    );

    assign accept_valid = arb_valid && buf_ready;
    assign accept_index = arb_index;

    // an accepted beat shows up on the output next cycle
    a_accept_visible: assert property (
        @(posedge clk) disable iff (rst)
        accept_valid |=> valid_out
    );

endmodule

// File: src/arb_csr.sv
// AXI4-Lite register block for the merger, holds mode and enable mask and counts accepted beats
`timescale 1ns/10ps

module arb_csr (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic [stream_arb_pkg::AXI_ADDR_W-1:0] awaddr,
    input  logic                                  awvalid,
    output logic                                  awready,
    input  logic [stream_arb_pkg::AXI_DATA_W-1:0] wdata,
    input  logic [stream_arb_pkg::AXI_STRB_W-1:0] wstrb,
    input  logic                                  wvalid,
    output logic                                  wready,
    output logic [1:0]                            bresp,
    output logic                                  bvalid,
    input  logic                                  bready,
    input  logic [stream_arb_pkg::AXI_ADDR_W-1:0] araddr,
    input  logic                                  arvalid,
    output logic                                  arready,
    output logic [stream_arb_pkg::AXI_DATA_W-1:0] rdata,
    output logic [1:0]                            rresp,
    output logic                                  rvalid,
    input  logic                                  rready,
    output logic                                  mode,
    output logic [stream_arb_pkg::NUM_INPUTS-1:0] enable_mask,
    input  logic                                  accept_valid,
    input  logic [stream_arb_pkg::SEL_W-1:0]      accept_index
);
    import stream_arb_pkg::*;

    logic [CNT_W-1:0]      cnt [NUM_INPUTS];
    logic [NUM_INPUTS-1:0] cnt_clear;
    logic                  wr_fire;
    logic                  rd_fire;
    logic                  wr_ctrl;
    logic                  wr_cnt;
    logic [AXI_DATA_W-1:0] rd_word;
    logic [1:0]            rd_resp;

    // word aligned and inside the counter window
    function automatic logic is_cnt_addr(input logic [AXI_ADDR_W-1:0] addr);
        return (addr >= REG_CNT_BASE)
            && (addr < AXI_ADDR_W'(REG_CNT_BASE + 4 * NUM_INPUTS))
            && (addr[1:0] == 2'b00);
    endfunction

    function automatic logic [SEL_W-1:0] cnt_index(input logic [AXI_ADDR_W-1:0] addr);
        logic [AXI_ADDR_W-1:0] offset;
        offset = addr - REG_CNT_BASE;
        return offset[SEL_W+1:2];
    endfunction

    // one write and one read in flight at most
    assign wr_fire = awvalid && wvalid && !bvalid;
    assign rd_fire = arvalid && !rvalid;
    assign awready = wr_fire;
    assign wready  = wr_fire;
    assign arready = rd_fire;

    assign wr_ctrl = wr_fire && (awaddr == REG_CTRL);
    assign wr_cnt  = wr_fire && is_cnt_addr(awaddr);

    always_comb begin
        cnt_clear = '0;
        if (wr_cnt) begin
            cnt_clear[cnt_index(awaddr)] = 1'b1;
        end
    end

    // mode and mask share the low byte
    always_ff @(posedge clk) begin
        if (rst) begin
            mode        <= ARB_MODE_RR;
            enable_mask <= '1;
        end else if (wr_ctrl && wstrb[0]) begin
            mode        <= wdata[CTRL_MODE_BIT];
            enable_mask <= wdata[CTRL_MASK_LSB +: NUM_INPUTS];
        end
    end

    // clear beats a same-cycle increment
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_INPUTS; i++) begin
                cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_INPUTS; i++) begin
                if (cnt_clear[i]) begin
                    cnt[i] <= '0;
                end else if (accept_valid && (accept_index == SEL_W'(i))) begin
                    cnt[i] <= cnt[i] + 1'b1;
                end
            end
        end
    end

    always_comb begin
        rd_word = '0;
        rd_resp = RESP_OKAY;
        if (araddr == REG_CTRL) begin
            rd_word[CTRL_MODE_BIT] = mode;
            rd_word[CTRL_MASK_LSB +: NUM_INPUTS] = enable_mask;
        end else if (is_cnt_addr(araddr)) begin
            rd_word = AXI_DATA_W'(cnt[cnt_index(araddr)]);
        end else begin
            rd_resp = RESP_SLVERR;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (rd_fire) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // response payloads, captured at acceptance
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            bresp <= (wr_ctrl || wr_cnt) ? RESP_OKAY : RESP_SLVERR;
        end
        if (rd_fire) begin
            rdata <= rd_word;
            rresp <= rd_resp;
        end
    end

    a_bvalid_hold: assert property (
        @(posedge clk) disable iff (rst)
        (bvalid && !bready) |=> (bvalid && $stable(bresp))
    );

    a_rvalid_hold: assert property (
        @(posedge clk) disable iff (rst)
        (rvalid && !rready) |=> (rvalid && $stable(rdata))
    );

endmodule

// File: src/stream_arb_top.sv
// top level of the merger, joins the stream path to its AXI4-Lite register block
`timescale 1ns/10ps

module stream_arb_top (
    input  logic                                                         clk,
    input  logic                                                         rst,
    input  logic [stream_arb_pkg::NUM_INPUTS-1:0]                        valid_in,
    input  logic [stream_arb_pkg::NUM_INPUTS-1:0][stream_arb_pkg::DATA_W-1:0] data_in,
    output logic [stream_arb_pkg::NUM_INPUTS-1:0]                        ready_in,
    output logic                                                         valid_out,
    output logic [stream_arb_pkg::DATA_W-1:0]                            data_out,
    output logic [stream_arb_pkg::SEL_W-1:0]                             sel_out,
    input  logic                                                         ready_out,
    input  logic [stream_arb_pkg::AXI_ADDR_W-1:0]                        awaddr,
    input  logic                                                         awvalid,
    output logic                                                         awready,
    input  logic [stream_arb_pkg::AXI_DATA_W-1:0]                        wdata,
    input  logic [stream_arb_pkg::AXI_STRB_W-1:0]                        wstrb,
    input  logic                                                         wvalid,
    output logic                                                         wready,
    output logic [1:0]                                                   bresp,
    output logic                                                         bvalid,
    input  logic                                                         bready,
    input  logic [stream_arb_pkg::AXI_ADDR_W-1:0]                        araddr,
    input  logic                                                         arvalid,
    output logic                                                         arready,
    output logic [stream_arb_pkg::AXI_DATA_W-1:0]                        rdata,
    output logic [1:0]                                                   rresp,
    output logic                                                         rvalid,
    input  logic                                                         rready
);
    import stream_arb_pkg::*;

    logic                  mode;
    logic [NUM_INPUTS-1:0] enable_mask;
    logic                  accept_valid;
    logic [SEL_W-1:0]      accept_index;

    stream_arb u_stream_arb (
        .clk          (clk),
        .rst          (rst),
        .valid_in     (valid_in),
        .data_in      (data_in),
        .ready_in     (ready_in),
        .valid_out    (valid_out),
        .data_out     (data_out),
        .sel_out      (sel_out),
        .ready_out    (ready_out),
        .mode         (mode),
        .enable_mask  (enable_mask),
        .accept_valid (accept_valid),
        .accept_index (accept_index)
    );

    arb_csr u_csr (
        .clk          (clk),
        .rst          (rst),
        .awaddr       (awaddr),
        .awvalid      (awvalid),
        .awready      (awready),
        .wdata        (wdata),
        .wstrb        (wstrb),
        .wvalid       (wvalid),
        .wready       (wready),
        .bresp        (bresp),
        .bvalid       (bvalid),
        .bready       (bready),
        .araddr       (araddr),
        .arvalid      (arvalid),
        .arready      (arready),
        .rdata        (rdata),
        .rresp        (rresp),
        .rvalid       (rvalid),
        .rready       (rready),
        .mode         (mode),
        .enable_mask  (enable_mask),
        .accept_valid (accept_valid),
        .accept_index (accept_index)
    );

endmodule

// File: verification/stream_arb_tb.sv
// testbench for the stream merger, applies a table of arbitration rows and checks beats and counters
`timescale 1ns/10ps

module stream_arb_tb;
    import stream_arb_pkg::*;

    typedef struct packed {
        logic                  mode;
        logic [NUM_INPUTS-1:0] mask;
        logic [NUM_INPUTS-1:0] active;
        logic [15:0]           beats;
        logic [7:0]            ready_pct;
    } row_t;

    localparam int NUM_ROWS = 5;
    // mode, enable mask, active inputs, beats per input, ready_out percentage
    localparam row_t ROWS [NUM_ROWS] = '{
        '{ARB_MODE_RR,   4'hF, 4'hF, 16'd12, 8'd100},
        '{ARB_MODE_PRIO, 4'hE, 4'h7, 16'd10, 8'd100},
        '{ARB_MODE_RR,   4'h5, 4'hF, 16'd8,  8'd75},
        '{ARB_MODE_PRIO, 4'hF, 4'hB, 16'd15, 8'd60},
        '{ARB_MODE_RR,   4'hF, 4'hF, 16'd20, 8'd40}
    };
    string row_names [NUM_ROWS] = '{
        "round_robin", "prio_masked", "partial_rr", "backpressure_prio", "backpressure_rr"
    };

    logic                              clk = 1'b0;
    logic                              rst = 1'b1;
    logic [NUM_INPUTS-1:0]             valid_in = '0;
    logic [NUM_INPUTS-1:0][DATA_W-1:0] data_in = '0;
    logic [NUM_INPUTS-1:0]             ready_in;
    logic                              valid_out;
    logic [DATA_W-1:0]                 data_out;
    logic [SEL_W-1:0]                  sel_out;
    logic                              ready_out = 1'b1;
    logic [AXI_ADDR_W-1:0]             awaddr;
    logic                              awvalid;
    logic                              awready;
    logic [AXI_DATA_W-1:0]             wdata;
    logic [AXI_STRB_W-1:0]             wstrb;
    logic                              wvalid;
    logic                              wready;
    logic [1:0]                        bresp;
    logic                              bvalid;
    logic                              bready;
    logic [AXI_ADDR_W-1:0]             araddr;
    logic                              arvalid;
    logic                              arready;
    logic [AXI_DATA_W-1:0]             rdata;
    logic [1:0]                        rresp;
    logic                              rvalid;
    logic                              rready;

    // row settings that change only while the streams are idle
    logic                  running = 1'b0;
    logic                  mode_cfg = 1'b0;
    logic [NUM_INPUTS-1:0] mask_cfg = '1;
    logic [NUM_INPUTS-1:0] active_cfg = '0;
    int                    beats_cfg = 0;
    int                    pct_cfg = 100;
    int                    seed = 32'h23101adf;
    string                 test_name = "reset_values";
    int                    sent [NUM_INPUTS];
    int                    received [NUM_INPUTS];
    int                    expected_cnt [NUM_INPUTS];
    logic [SEL_W-1:0]      last_sel;

    stream_arb_top UUT (
        .clk       (clk),
        .rst       (rst),
        .valid_in  (valid_in),
        .data_in   (data_in),
        .ready_in  (ready_in),
        .valid_out (valid_out),
        .data_out  (data_out),
        .sel_out   (sel_out),
        .ready_out (ready_out),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wvalid    (wvalid),
        .wready    (wready),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rresp     (rresp),
        .rvalid    (rvalid),
        .rready    (rready)
    );

    always #2 clk = ~clk;

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("Something failed");
        $fatal(1, "stopping at the first failure");
    endtask

    task automatic compare_value(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            fail_run($sformatf("error in %s, %s: expected %0h, actual %0h",
                               test_name, what, expected, actual));
        end
    endtask

    task automatic axi_write(input logic [AXI_ADDR_W-1:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        @(posedge clk);
        awaddr  <= addr;
        awvalid <= 1'b1;
        wdata   <= data;
        wstrb   <= '1;
        wvalid  <= 1'b1;
        bready  <= 1'b1;
        do @(posedge clk); while (!(awready && wready));
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        do @(posedge clk); while (!bvalid);
        resp = bresp;
        bready <= 1'b0;
    endtask

    task automatic axi_read(input logic [AXI_ADDR_W-1:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        rready  <= 1'b1;
        do @(posedge clk); while (!arready);
        arvalid <= 1'b0;
        do @(posedge clk); while (!rvalid);
        data = rdata;
        resp = rresp;
        rready <= 1'b0;
    endtask

    task automatic read_expect(input string what, input logic [AXI_ADDR_W-1:0] addr,
                               input logic [31:0] exp_data, input logic [1:0] exp_resp);
        logic [31:0] data;
        logic [1:0]  resp;
        axi_read(addr, data, resp);
        compare_value({what, " data"}, exp_data, data);
        compare_value({what, " response"}, 32'(exp_resp), 32'(resp));
    endtask

    function automatic logic [AXI_ADDR_W-1:0] counter_addr(input int idx);
        return AXI_ADDR_W'(int'(REG_CNT_BASE) + 4 * idx);
    endfunction

    // round-robin starts after the last taken source and fixed priority at input 0
    function automatic logic [SEL_W-1:0] next_source();
        int   idx;
        logic found;
        logic [SEL_W-1:0] result;
        found = 1'b0;
        result = '0;
        for (int k = 1; k <= NUM_INPUTS; k++) begin
            idx = (mode_cfg == ARB_MODE_PRIO) ? k - 1 : (int'(last_sel) + k) % NUM_INPUTS;
            if (!found && received[idx] < expected_cnt[idx]) begin
                result = SEL_W'(idx);
                found = 1'b1;
            end
        end
        return result;
    endfunction

    function automatic int total_beats();
        int sum;
        sum = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            sum += int'(ROWS[r].beats) * $countones(ROWS[r].active & ROWS[r].mask);
        end
        return sum;
    endfunction

    // sources hold valid while beats remain and send the input number over a sequence count
    always @(posedge clk) begin : drive_sources
        int next_seq;
        for (int i = 0; i < NUM_INPUTS; i++) begin
            if (rst || !running) begin
                sent[i]     <= 0;
                valid_in[i] <= 1'b0;
            end else begin
                next_seq = sent[i] + ((valid_in[i] && ready_in[i]) ? 1 : 0);
                sent[i]     <= next_seq;
                valid_in[i] <= active_cfg[i] && (next_seq < beats_cfg);
                data_in[i]  <= {8'(i), 24'(next_seq)};
            end
        end
        if (running) begin
            ready_out <= (($random(seed) & 32'h7fff_ffff) % 100) < pct_cfg;
        end else begin
            ready_out <= 1'b1;
        end
    end

    always @(posedge clk) begin : watch_output
        logic [SEL_W-1:0] want;
        if (rst) begin
            last_sel = SEL_W'(NUM_INPUTS - 1);
        end
        if (rst || !running) begin
            for (int i = 0; i < NUM_INPUTS; i++) begin
                received[i] = 0;
            end
        end else begin
            compare_value("ready of masked inputs", 32'(0), 32'(ready_in & ~mask_cfg));
            if (valid_out && ready_out) begin
                if (received[sel_out] >= expected_cnt[sel_out]) begin
                    fail_run($sformatf("%s: input %0d delivered more than its %0d beats",
                                       test_name, sel_out, expected_cnt[sel_out]));
                end else begin
                    want = next_source();
                    compare_value("source byte", 32'(sel_out), 32'(data_out[DATA_W-1 -: 8]));
                    compare_value("sequence count", 32'(received[sel_out]),
                                  32'(data_out[23:0]));
                    compare_value("arbitration order", 32'(want), 32'(sel_out));
                    received[sel_out] = received[sel_out] + 1;
                    last_sel = sel_out;
                end
            end
        end
    end

    task automatic wait_drained();
        logic done;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = 1'b1;
            for (int i = 0; i < NUM_INPUTS; i++) begin
                if (received[i] != expected_cnt[i]) begin
                    done = 1'b0;
                end
            end
        end
    endtask

    task automatic run_row(input int r);
        row_t        row;
        logic [1:0]  resp;
        logic [31:0] ctrl_word;
        row = ROWS[r];
        test_name = row_names[r];
        ctrl_word = (32'(row.mask) << CTRL_MASK_LSB) | (32'(row.mode) << CTRL_MODE_BIT);
        axi_write(REG_CTRL, ctrl_word, resp);
        compare_value("control write response", 32'(RESP_OKAY), 32'(resp));
        read_expect("control readback", REG_CTRL, ctrl_word, RESP_OKAY);
        for (int i = 0; i < NUM_INPUTS; i++) begin
            axi_write(counter_addr(i), 32'h0, resp);
            compare_value("counter clear response", 32'(RESP_OKAY), 32'(resp));
        end
        mode_cfg   = row.mode;
        mask_cfg   = row.mask;
        active_cfg = row.active;
        beats_cfg  = int'(row.beats);
        pct_cfg    = int'(row.ready_pct);
        for (int i = 0; i < NUM_INPUTS; i++) begin
            expected_cnt[i] = (row.active[i] && row.mask[i]) ? int'(row.beats) : 0;
        end
        @(posedge clk);
        running <= 1'b1;
        wait_drained();
        @(posedge clk);
        running <= 1'b0;
        repeat (3) @(posedge clk);
        compare_value("output idle after drain", 32'(0), 32'(valid_out));
        for (int i = 0; i < NUM_INPUTS; i++) begin
            read_expect($sformatf("counter %0d", i), counter_addr(i),
                        32'(expected_cnt[i]), RESP_OKAY);
        end
    endtask

    initial begin : run_tests
        logic [1:0] resp;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        read_expect("control after reset", REG_CTRL, 32'(4'hF) << CTRL_MASK_LSB, RESP_OKAY);
        for (int i = 0; i < NUM_INPUTS; i++) begin
            read_expect($sformatf("counter %0d after reset", i), counter_addr(i), 32'h0,
                        RESP_OKAY);
        end
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        test_name = "register_errors";
        read_expect("unmapped read", 8'h40, 32'h0, RESP_SLVERR);
        axi_write(8'h44, 32'h1234_5678, resp);
        compare_value("unmapped write response", 32'(RESP_SLVERR), 32'(resp));
        // counter 2 is cleared while the others keep the counts of the last row
        test_name = "counter_clear";
        axi_write(counter_addr(2), 32'h0, resp);
        compare_value("clear response", 32'(RESP_OKAY), 32'(resp));
        for (int i = 0; i < NUM_INPUTS; i++) begin
            read_expect($sformatf("counter %0d", i), counter_addr(i),
                        (i == 2) ? 32'h0 : 32'(expected_cnt[i]), RESP_OKAY);
        end
        $display("Everything OK");
        $finish;
    end

    // eight cycles per beat plus room for reset and register traffic
    initial begin : watchdog
        int limit;
        limit = total_beats() * 8 + 1000;
        repeat (limit) @(posedge clk);
        fail_run($sformatf("timeout after %0d cycles, the run did not complete", limit));
    end

endmodule

// File: filelist.f
src/stream_arb_pkg.sv
src/stream_arbiter.sv
src/elastic_buffer.sv
src/stream_arb.sv
src/arb_csr.sv
src/stream_arb_top.sv
verification/stream_arb_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the stream merger testbench with Verilator, runs it and looks for the pass message

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
    -f filelist.f --top-module stream_arb_tb -Mdir "$BUILD_DIR" -o sim_stream_arb
status=$?
if [ $status -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

output=$("./$BUILD_DIR/sim_stream_arb" 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "Everything OK"; then
    exit 0
else
    echo "pass message not found"
    exit 1
fi
